// ==== verilog/wb_xbar_pkg.sv ====
`default_nettype none

package wb_xbar_pkg;

	// Two bus masters share the fabric
	localparam int N_MASTERS = 2;

	// Slave 0, slave 1 and the decode-fail target
	localparam int N_TARGETS = 3;

	// Index of the internal decode-fail target
	localparam int TGT_ERR = 2;

	// Master index, wide enough for N_MASTERS
	typedef logic [0:0] master_id_t;

	// Target index
	// 0 and 1 are the slaves, 2 is decode-fail
	typedef logic [1:0] target_id_t;

	// Per-master transaction tracking
	typedef enum logic {
		// No transfer tracked
		M_IDLE,
		// Waiting for ACK or ERR from the selected target
		M_WAIT
	} master_state_e;

endpackage

`default_nettype wire

// ==== verilog/wb_xbar_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_xbar_ctrl #(
	parameter int ADDR_W = 32,
	parameter logic [ADDR_W-1:0] S0_BASE = '0,
	parameter logic [ADDR_W-1:0] S0_LIMIT = '0,
	parameter logic [ADDR_W-1:0] S1_BASE = '0,
	parameter logic [ADDR_W-1:0] S1_LIMIT = '0
) (
	input wire clk,
	input wire rstn,
	input wire [wb_xbar_pkg::N_MASTERS-1:0] m_cyc_i,
	input wire [wb_xbar_pkg::N_MASTERS-1:0] m_stb_i,
	input wire [ADDR_W-1:0] m0_adr_i,
	input wire [ADDR_W-1:0] m1_adr_i,
	input wire [wb_xbar_pkg::N_MASTERS-1:0] m_ack_i,
	input wire [wb_xbar_pkg::N_MASTERS-1:0] m_err_i,
	output wb_xbar_pkg::target_id_t m0_sel_tgt_o,
	output wb_xbar_pkg::target_id_t m1_sel_tgt_o,
	output logic [wb_xbar_pkg::N_MASTERS-1:0] busy_o,
	output logic [wb_xbar_pkg::N_MASTERS-1:0] tgt0_req_o,
	output logic [wb_xbar_pkg::N_MASTERS-1:0] tgt1_req_o,
	output logic [wb_xbar_pkg::N_MASTERS-1:0] tgt2_req_o
);
	import wb_xbar_pkg::*;

	// Master addresses gathered for indexed access
	logic [ADDR_W-1:0] adr [N_MASTERS];

	// Transaction state and latched target per master
	master_state_e state [N_MASTERS];
	target_id_t sel_tgt [N_MASTERS];

	// Map an address onto a target, decode-fail when no window hits
	function automatic target_id_t decode(input logic [ADDR_W-1:0] a);
		target_id_t tgt;
		tgt = target_id_t'(TGT_ERR);
		if (a >= S0_BASE && a <= S0_LIMIT) begin
			tgt = target_id_t'(0);
		end else if (a >= S1_BASE && a <= S1_LIMIT) begin
			tgt = target_id_t'(1);
		end
		return tgt;
	endfunction

	assign adr[0] = m0_adr_i;
	assign adr[1] = m1_adr_i;

	// One IDLE/WAIT machine per master
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				state[m] <= M_IDLE;
				sel_tgt[m] <= target_id_t'(TGT_ERR);
			end
		end else begin
			for (int m = 0; m < N_MASTERS; m++) begin
				case (state[m])
					M_IDLE: begin
						// New strobe, capture where it is going
						if (m_cyc_i[m] && m_stb_i[m]) begin
							state[m] <= M_WAIT;
							sel_tgt[m] <= decode(adr[m]);
						end
					end
					M_WAIT: begin
						// Either response closes the transfer
						if (m_ack_i[m] || m_err_i[m]) begin
							state[m] <= M_IDLE;
						end
					end
					default: begin
						state[m] <= M_IDLE;
					end
				endcase
			end
		end
	end

	assign m0_sel_tgt_o = sel_tgt[0];
	assign m1_sel_tgt_o = sel_tgt[1];

	// Busy masters raise their bit in the request vector of their target
	always_comb begin
		busy_o = '0;
		tgt0_req_o = '0;
		tgt1_req_o = '0;
		tgt2_req_o = '0;
		for (int m = 0; m < N_MASTERS; m++) begin
			busy_o[m] = (state[m] == M_WAIT);
			tgt0_req_o[m] = busy_o[m] && (sel_tgt[m] == target_id_t'(0));
			tgt1_req_o[m] = busy_o[m] && (sel_tgt[m] == target_id_t'(1));
			tgt2_req_o[m] = busy_o[m] && (sel_tgt[m] == target_id_t'(TGT_ERR));
		end
	end

endmodule

`default_nettype wire

// ==== verilog/wb_rr_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_rr_arbiter #(
	parameter int N_REQ = 2
) (
	input wire clk,
	input wire rstn,
	input wire [N_REQ-1:0] req_i,
	output logic gnt_o,
	output wb_xbar_pkg::master_id_t gnt_id_o
);
	import wb_xbar_pkg::*;

	// Registered grant, id keeps the last grantee once released
	logic gnt_q;
	master_id_t gnt_id_q;

	// Candidate selection
	master_id_t lowest;
	master_id_t above;
	logic has_above;
	master_id_t next_id;

	// Walk down so the lowest matching index wins in each class
	always_comb begin
		lowest = '0;
		above = '0;
		has_above = 1'b0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				lowest = master_id_t'(i);
				// First requester above the last grantee
				if (i > int'(gnt_id_q)) begin
					above = master_id_t'(i);
					has_above = 1'b1;
				end
			end
		end
		// Wrap around to the lowest requester
		next_id = has_above ? above : lowest;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q <= 1'b0;
			// Last grantee at the top so the first grant goes to index 0
			gnt_id_q <= master_id_t'(N_REQ - 1);
		end else if (!gnt_q) begin
			if (|req_i) begin
				gnt_q <= 1'b1;
				gnt_id_q <= next_id;
			end
		end else if (!req_i[gnt_id_q]) begin
			// Owner done, release on this edge
			gnt_q <= 1'b0;
		end
	end

	// Owner's request masks the grant
	// so a target sees nothing in the cycle before release
	assign gnt_o = gnt_q & req_i[gnt_id_q];
	assign gnt_id_o = gnt_id_q;

endmodule

`default_nettype wire

// ==== verilog/wb_req_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_req_mux #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input wire gnt_i,
	input wb_xbar_pkg::master_id_t gnt_id_i,
	input wire m0_cyc_i,
	input wire m0_stb_i,
	input wire m0_we_i,
	input wire [ADDR_W-1:0] m0_adr_i,
	input wire [DATA_W/8-1:0] m0_sel_i,
	input wire [DATA_W-1:0] m0_dat_i,
	input wire m1_cyc_i,
	input wire m1_stb_i,
	input wire m1_we_i,
	input wire [ADDR_W-1:0] m1_adr_i,
	input wire [DATA_W/8-1:0] m1_sel_i,
	input wire [DATA_W-1:0] m1_dat_i,
	output logic t_cyc_o,
	output logic t_stb_o,
	output logic t_we_o,
	output logic [ADDR_W-1:0] t_adr_o,
	output logic [DATA_W/8-1:0] t_sel_o,
	output logic [DATA_W-1:0] t_dat_o
);

	always_comb begin
		// Target idles at zero without a grant
		t_cyc_o = 1'b0;
		t_stb_o = 1'b0;
		t_we_o = 1'b0;
		t_adr_o = '0;
		t_sel_o = '0;
		t_dat_o = '0;
		if (gnt_i) begin
			if (gnt_id_i == 1'b0) begin
				t_cyc_o = m0_cyc_i;
				t_stb_o = m0_stb_i;
				t_we_o = m0_we_i;
				t_adr_o = m0_adr_i;
				t_sel_o = m0_sel_i;
				t_dat_o = m0_dat_i;
			end else begin
				t_cyc_o = m1_cyc_i;
				t_stb_o = m1_stb_i;
				t_we_o = m1_we_i;
				t_adr_o = m1_adr_i;
				t_sel_o = m1_sel_i;
				t_dat_o = m1_dat_i;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/wb_resp_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_resp_mux #(
	parameter int MASTER_ID = 0,
	parameter int DATA_W = 32
) (
	input wb_xbar_pkg::target_id_t sel_tgt_i,
	input wire busy_i,
	input wire [wb_xbar_pkg::N_TARGETS-1:0] gnt_i,
	input wb_xbar_pkg::master_id_t gnt_id0_i,
	input wb_xbar_pkg::master_id_t gnt_id1_i,
	input wb_xbar_pkg::master_id_t gnt_id2_i,
	input wire [wb_xbar_pkg::N_TARGETS-1:0] t_ack_i,
	input wire [wb_xbar_pkg::N_TARGETS-1:0] t_err_i,
	input wire [DATA_W-1:0] t0_dat_i,
	input wire [DATA_W-1:0] t1_dat_i,
	input wire [DATA_W-1:0] t2_dat_i,
	output logic ack_o,
	output logic err_o,
	output logic [DATA_W-1:0] dat_o
);
	import wb_xbar_pkg::*;

	// Per-target grant owner and read data, indexed by target
	master_id_t gnt_id [N_TARGETS];
	logic [DATA_W-1:0] t_dat [N_TARGETS];

	assign gnt_id[0] = gnt_id0_i;
	assign gnt_id[1] = gnt_id1_i;
	assign gnt_id[2] = gnt_id2_i;
	assign t_dat[0] = t0_dat_i;
	assign t_dat[1] = t1_dat_i;
	assign t_dat[2] = t2_dat_i;

	always_comb begin
		ack_o = 1'b0;
		err_o = 1'b0;
		dat_o = '0;
		for (int t = 0; t < N_TARGETS; t++) begin
			// Only the owner of the selected target hears its response
			if (busy_i && sel_tgt_i == target_id_t'(t) && gnt_i[t] &&
					gnt_id[t] == master_id_t'(MASTER_ID)) begin
				ack_o = t_ack_i[t];
				err_o = t_err_i[t];
				dat_o = t_dat[t];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/wb_decode_err.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_decode_err #(
	parameter int DATA_W = 32
) (
	input wire clk,
	input wire rstn,
	input wire cyc_i,
	input wire stb_i,
	output logic err_o,
	output logic [DATA_W-1:0] dat_o
);

	logic err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			// One ERR per strobe, the master is still holding STB while ERR is out
			err_q <= cyc_i & stb_i & ~err_q;
		end
	end

	assign err_o = err_q;
	// Nothing to read here
	assign dat_o = '0;

endmodule

`default_nettype wire

// ==== verilog/wb_xbar_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_xbar_top #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32,
	parameter logic [ADDR_W-1:0] S0_BASE = 'h0000,
	parameter logic [ADDR_W-1:0] S0_LIMIT = 'h0fff,
	parameter logic [ADDR_W-1:0] S1_BASE = 'h1000,
	parameter logic [ADDR_W-1:0] S1_LIMIT = 'h1fff
) (
	input wire clk,
	input wire rstn,
	input wire m0_cyc_i,
	input wire m0_stb_i,
	input wire m0_we_i,
	input wire [ADDR_W-1:0] m0_adr_i,
	input wire [DATA_W/8-1:0] m0_sel_i,
	input wire [DATA_W-1:0] m0_dat_i,
	output wire m0_ack_o,
	output wire m0_err_o,
	output wire [DATA_W-1:0] m0_dat_o,
	input wire m1_cyc_i,
	input wire m1_stb_i,
	input wire m1_we_i,
	input wire [ADDR_W-1:0] m1_adr_i,
	input wire [DATA_W/8-1:0] m1_sel_i,
	input wire [DATA_W-1:0] m1_dat_i,
	output wire m1_ack_o,
	output wire m1_err_o,
	output wire [DATA_W-1:0] m1_dat_o,
	output wire s0_cyc_o,
	output wire s0_stb_o,
	output wire s0_we_o,
	output wire [ADDR_W-1:0] s0_adr_o,
	output wire [DATA_W/8-1:0] s0_sel_o,
	output wire [DATA_W-1:0] s0_dat_o,
	input wire s0_ack_i,
	input wire s0_err_i,
	input wire [DATA_W-1:0] s0_dat_i,
	output wire s1_cyc_o,
	output wire s1_stb_o,
	output wire s1_we_o,
	output wire [ADDR_W-1:0] s1_adr_o,
	output wire [DATA_W/8-1:0] s1_sel_o,
	output wire [DATA_W-1:0] s1_dat_o,
	input wire s1_ack_i,
	input wire s1_err_i,
	input wire [DATA_W-1:0] s1_dat_i
);
	import wb_xbar_pkg::*;

	logic [N_MASTERS-1:0] busy;
	target_id_t m0_sel_tgt;
	target_id_t m1_sel_tgt;
	logic [N_MASTERS-1:0] tgt_req [N_TARGETS];
	logic [N_TARGETS-1:0] gnt;
	master_id_t gnt_id [N_TARGETS];

	// Decode-fail target side
	logic derr_cyc;
	logic derr_stb;
	logic derr_err;
	logic [DATA_W-1:0] derr_dat;

	// Responses of all targets, decode-fail never ACKs
	logic [N_TARGETS-1:0] t_ack;
	logic [N_TARGETS-1:0] t_err;

	assign t_ack = {1'b0, s1_ack_i, s0_ack_i};
	assign t_err = {derr_err, s1_err_i, s0_err_i};

	wb_xbar_ctrl #(
		.ADDR_W(ADDR_W), .S0_BASE(S0_BASE), .S0_LIMIT(S0_LIMIT),
		.S1_BASE(S1_BASE), .S1_LIMIT(S1_LIMIT)
	) u_ctrl (
		.clk(clk), .rstn(rstn),
		.m_cyc_i({m1_cyc_i, m0_cyc_i}), .m_stb_i({m1_stb_i, m0_stb_i}),
		.m0_adr_i(m0_adr_i), .m1_adr_i(m1_adr_i),
		.m_ack_i({m1_ack_o, m0_ack_o}), .m_err_i({m1_err_o, m0_err_o}),
		.m0_sel_tgt_o(m0_sel_tgt), .m1_sel_tgt_o(m1_sel_tgt), .busy_o(busy),
		.tgt0_req_o(tgt_req[0]), .tgt1_req_o(tgt_req[1]), .tgt2_req_o(tgt_req[2])
	);

	// One arbiter per target
	for (genvar t = 0; t < N_TARGETS; t++) begin : g_arb
		wb_rr_arbiter #(.N_REQ(N_MASTERS)) u_arb (
			.clk(clk), .rstn(rstn), .req_i(tgt_req[t]),
			.gnt_o(gnt[t]), .gnt_id_o(gnt_id[t])
		);
	end

	wb_req_mux #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_req_s0 (
		.gnt_i(gnt[0]), .gnt_id_i(gnt_id[0]),
		.m0_cyc_i(m0_cyc_i), .m0_stb_i(m0_stb_i), .m0_we_i(m0_we_i),
		.m0_adr_i(m0_adr_i), .m0_sel_i(m0_sel_i), .m0_dat_i(m0_dat_i),
		.m1_cyc_i(m1_cyc_i), .m1_stb_i(m1_stb_i), .m1_we_i(m1_we_i),
		.m1_adr_i(m1_adr_i), .m1_sel_i(m1_sel_i), .m1_dat_i(m1_dat_i),
		.t_cyc_o(s0_cyc_o), .t_stb_o(s0_stb_o), .t_we_o(s0_we_o),
		.t_adr_o(s0_adr_o), .t_sel_o(s0_sel_o), .t_dat_o(s0_dat_o)
	);

	wb_req_mux #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_req_s1 (
		.gnt_i(gnt[1]), .gnt_id_i(gnt_id[1]),
		.m0_cyc_i(m0_cyc_i), .m0_stb_i(m0_stb_i), .m0_we_i(m0_we_i),
		.m0_adr_i(m0_adr_i), .m0_sel_i(m0_sel_i), .m0_dat_i(m0_dat_i),
		.m1_cyc_i(m1_cyc_i), .m1_stb_i(m1_stb_i), .m1_we_i(m1_we_i),
		.m1_adr_i(m1_adr_i), .m1_sel_i(m1_sel_i), .m1_dat_i(m1_dat_i),
		.t_cyc_o(s1_cyc_o), .t_stb_o(s1_stb_o), .t_we_o(s1_we_o),
		.t_adr_o(s1_adr_o), .t_sel_o(s1_sel_o), .t_dat_o(s1_dat_o)
	);

	// Decode-fail target only looks at CYC and STB
	wb_req_mux #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_req_err (
		.gnt_i(gnt[TGT_ERR]), .gnt_id_i(gnt_id[TGT_ERR]),
		.m0_cyc_i(m0_cyc_i), .m0_stb_i(m0_stb_i), .m0_we_i(m0_we_i),
		.m0_adr_i(m0_adr_i), .m0_sel_i(m0_sel_i), .m0_dat_i(m0_dat_i),
		.m1_cyc_i(m1_cyc_i), .m1_stb_i(m1_stb_i), .m1_we_i(m1_we_i),
		.m1_adr_i(m1_adr_i), .m1_sel_i(m1_sel_i), .m1_dat_i(m1_dat_i),
		.t_cyc_o(derr_cyc), .t_stb_o(derr_stb), .t_we_o(),
		.t_adr_o(), .t_sel_o(), .t_dat_o()
	);

	wb_decode_err #(.DATA_W(DATA_W)) u_derr (
		.clk(clk), .rstn(rstn), .cyc_i(derr_cyc), .stb_i(derr_stb),
		.err_o(derr_err), .dat_o(derr_dat)
	);

	wb_resp_mux #(.MASTER_ID(0), .DATA_W(DATA_W)) u_resp_m0 (
		.sel_tgt_i(m0_sel_tgt), .busy_i(busy[0]), .gnt_i(gnt),
		.gnt_id0_i(gnt_id[0]), .gnt_id1_i(gnt_id[1]), .gnt_id2_i(gnt_id[2]),
		.t_ack_i(t_ack), .t_err_i(t_err),
		.t0_dat_i(s0_dat_i), .t1_dat_i(s1_dat_i), .t2_dat_i(derr_dat),
		.ack_o(m0_ack_o), .err_o(m0_err_o), .dat_o(m0_dat_o)
	);

	wb_resp_mux #(.MASTER_ID(1), .DATA_W(DATA_W)) u_resp_m1 (
		.sel_tgt_i(m1_sel_tgt), .busy_i(busy[1]), .gnt_i(gnt),
		.gnt_id0_i(gnt_id[0]), .gnt_id1_i(gnt_id[1]), .gnt_id2_i(gnt_id[2]),
		.t_ack_i(t_ack), .t_err_i(t_err),
		.t0_dat_i(s0_dat_i), .t1_dat_i(s1_dat_i), .t2_dat_i(derr_dat),
		.ack_o(m1_ack_o), .err_o(m1_err_o), .dat_o(m1_dat_o)
	);

endmodule

`default_nettype wire

// ==== sim/wb_xbar_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_xbar_props (
	input wire clk,
	input wire rstn,
	input wire m0_stb_i,
	input wire m0_ack_o,
	input wire m0_err_o,
	input wire m1_stb_i,
	input wire m1_ack_o,
	input wire m1_err_o,
	input wire s0_cyc_o,
	input wire s0_stb_o,
	input wire s1_cyc_o,
	input wire s1_stb_o
);

	// A master never gets both responses at once
	a_m0_resp_excl: assert property (@(posedge clk) disable iff (!rstn)
		!(m0_ack_o && m0_err_o)) else $error("master 0 sees ACK and ERR together");
	a_m1_resp_excl: assert property (@(posedge clk) disable iff (!rstn)
		!(m1_ack_o && m1_err_o)) else $error("master 1 sees ACK and ERR together");

	// Slave strobes only inside a bus cycle
	a_s0_stb_cyc: assert property (@(posedge clk) disable iff (!rstn)
		s0_stb_o |-> s0_cyc_o) else $error("slave 0 STB without CYC");
	a_s1_stb_cyc: assert property (@(posedge clk) disable iff (!rstn)
		s1_stb_o |-> s1_cyc_o) else $error("slave 1 STB without CYC");

	// ACK always answers a strobe seen on the edge before
	a_m0_ack_stb: assert property (@(posedge clk) disable iff (!rstn)
		m0_ack_o |-> $past(m0_stb_i)) else $error("master 0 ACK without STB");
	a_m1_ack_stb: assert property (@(posedge clk) disable iff (!rstn)
		m1_ack_o |-> $past(m1_stb_i)) else $error("master 1 ACK without STB");

endmodule

bind wb_xbar_top wb_xbar_props u_props (.*);

`default_nettype wire

// ==== sim/wb_xbar_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

// Word memory slave that acks one cycle after it sees STB
module mem_model (
	input wire clk,
	input wire rstn,
	input wire cyc_i,
	input wire stb_i,
	input wire we_i,
	input wire [31:0] adr_i,
	input wire [3:0] sel_i,
	input wire [31:0] dat_i,
	output logic ack_o,
	output logic [31:0] dat_o
);
	logic [31:0] mem [256];
	// Addresses in arrival order
	logic [31:0] adr_log [$];
	logic [7:0] idx;

	assign idx = adr_i[9:2];

	always @(posedge clk) begin
		if (!rstn) begin
			ack_o <= 1'b0;
			dat_o <= '0;
		end else begin
			// Single ACK even though the master still holds STB during it
			ack_o <= cyc_i & stb_i & ~ack_o;
			if (cyc_i && stb_i && !ack_o) begin
				adr_log.push_back(adr_i);
				dat_o <= mem[idx];
				if (we_i) begin
					// Byte lanes follow SEL
					for (int b = 0; b < 4; b++) begin
						if (sel_i[b]) begin
							mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
						end
					end
				end
			end
		end
	end
endmodule

module wb_xbar_tb;
	localparam int N_WORDS = 8;
	localparam int TIMEOUT = 100;

	logic clk;
	logic rstn;
	// Master side indexed by master number
	logic [1:0] cyc, stb, we;
	logic [31:0] adr [2];
	logic [3:0] sel [2];
	logic [31:0] wdat [2];
	wire [1:0] ack, err;
	wire [31:0] rdat0, rdat1;
	// Slave side
	wire s0_cyc, s0_stb, s0_we, s0_ack, s1_cyc, s1_stb, s1_we, s1_ack;
	wire [31:0] s0_adr, s0_dat, s0_rdat, s1_adr, s1_dat, s1_rdat;
	wire [3:0] s0_sel, s1_sel;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	logic [31:0] lcg_state = 32'd70;

	wb_xbar_top #(
		.S0_BASE(32'h0000), .S0_LIMIT(32'h0fff), .S1_BASE(32'h1000), .S1_LIMIT(32'h1fff)
	) UUT (
		.clk(clk), .rstn(rstn),
		.m0_cyc_i(cyc[0]), .m0_stb_i(stb[0]), .m0_we_i(we[0]), .m0_adr_i(adr[0]),
		.m0_sel_i(sel[0]), .m0_dat_i(wdat[0]), .m0_ack_o(ack[0]), .m0_err_o(err[0]),
		.m0_dat_o(rdat0),
		.m1_cyc_i(cyc[1]), .m1_stb_i(stb[1]), .m1_we_i(we[1]), .m1_adr_i(adr[1]),
		.m1_sel_i(sel[1]), .m1_dat_i(wdat[1]), .m1_ack_o(ack[1]), .m1_err_o(err[1]),
		.m1_dat_o(rdat1),
		.s0_cyc_o(s0_cyc), .s0_stb_o(s0_stb), .s0_we_o(s0_we), .s0_adr_o(s0_adr),
		.s0_sel_o(s0_sel), .s0_dat_o(s0_dat), .s0_ack_i(s0_ack), .s0_err_i(1'b0),
		.s0_dat_i(s0_rdat),
		.s1_cyc_o(s1_cyc), .s1_stb_o(s1_stb), .s1_we_o(s1_we), .s1_adr_o(s1_adr),
		.s1_sel_o(s1_sel), .s1_dat_o(s1_dat), .s1_ack_i(s1_ack), .s1_err_i(1'b0),
		.s1_dat_i(s1_rdat)
	);

	mem_model s0_mem (
		.clk(clk), .rstn(rstn), .cyc_i(s0_cyc), .stb_i(s0_stb), .we_i(s0_we),
		.adr_i(s0_adr), .sel_i(s0_sel), .dat_i(s0_dat), .ack_o(s0_ack), .dat_o(s0_rdat)
	);

	mem_model s1_mem (
		.clk(clk), .rstn(rstn), .cyc_i(s1_cyc), .stb_i(s1_stb), .we_i(s1_we),
		.adr_i(s1_adr), .sel_i(s1_sel), .dat_i(s1_dat), .ack_o(s1_ack), .dat_o(s1_rdat)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// LCG for write data
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		$display("%s finished with %0d errors", name, errors - errs_before);
	endtask

	// One classic transfer with STB held until the response and dropped one cycle later
	task automatic bus_access(input int m, input logic w, input logic [31:0] a,
			input logic [31:0] d, output logic [31:0] q, output logic got_ack,
			output logic got_err);
		int n;
		n = 0;
		q = '0;
		got_ack = 1'b0;
		got_err = 1'b0;
		@(posedge clk);
		#1;
		cyc[m] = 1'b1;
		stb[m] = 1'b1;
		we[m] = w;
		adr[m] = a;
		sel[m] = 4'hf;
		wdat[m] = d;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!ack[m] && !err[m] && n < TIMEOUT);
		if (ack[m] || err[m]) begin
			got_ack = ack[m];
			got_err = err[m];
			q = (m == 0) ? rdat0 : rdat1;
		end else begin
			$display("Master %0d got no ACK or ERR for address %h in time", m, a);
			errors++;
		end
		@(posedge clk);
		#1;
		cyc[m] = 1'b0;
		stb[m] = 1'b0;
		we[m] = 1'b0;
	endtask

	task automatic write_word(input string name, input int m, input logic [31:0] a,
			input logic [31:0] d);
		logic [31:0] q;
		logic a_ok, e_seen;
		bus_access(m, 1'b1, a, d, q, a_ok, e_seen);
		compare({name, " write ack"}, 32'd1, {31'd0, a_ok});
		compare({name, " write err"}, 32'd0, {31'd0, e_seen});
	endtask

	task automatic read_word(input string name, input int m, input logic [31:0] a,
			input logic [31:0] exp);
		logic [31:0] q;
		logic a_ok, e_seen;
		bus_access(m, 1'b0, a, 32'd0, q, a_ok, e_seen);
		compare({name, " read ack"}, 32'd1, {31'd0, a_ok});
		compare({name, " read err"}, 32'd0, {31'd0, e_seen});
		compare({name, " read data"}, exp, q);
	endtask

	// Write then read back a run of words from one master
	task automatic hammer(input string name, input int m, input logic [31:0] base);
		logic [31:0] d;
		for (int i = 0; i < N_WORDS; i++) begin
			d = next_random();
			write_word(name, m, base + 32'(4 * i), d);
			read_word(name, m, base + 32'(4 * i), d);
		end
	endtask

	task automatic reset_values();
		int e0;
		e0 = errors;
		compare("reset slave cyc stb", 32'd0, {28'd0, s0_cyc, s0_stb, s1_cyc, s1_stb});
		compare("reset master ack err", 32'd0, {28'd0, ack, err});
		report_test("reset_values", e0);
	endtask

	task automatic single_master_rw(input string name, input int m, input logic [31:0] base);
		logic [31:0] exp [N_WORDS];
		logic [31:0] stored;
		logic [7:0] idx;
		int e0;
		e0 = errors;
		for (int i = 0; i < N_WORDS; i++) begin
			exp[i] = next_random();
			write_word(name, m, base + 32'(4 * i), exp[i]);
		end
		for (int i = 0; i < N_WORDS; i++) begin
			read_word(name, m, base + 32'(4 * i), exp[i]);
			// Slave memory must hold the word as well
			idx = base[9:2] + 8'(i);
			stored = (m == 0) ? s0_mem.mem[idx] : s1_mem.mem[idx];
			compare({name, " memory"}, exp[i], stored);
		end
		report_test(name, e0);
	endtask

	task automatic decode_fail_access();
		logic [31:0] q, d, ok_adr;
		logic a_seen, e_seen;
		int n0, n1, e0;
		e0 = errors;
		for (int m = 0; m < 2; m++) begin
			n0 = s0_mem.adr_log.size();
			n1 = s1_mem.adr_log.size();
			bus_access(m, 1'b0, 32'h8000, 32'd0, q, a_seen, e_seen);
			compare("decode fail err", 32'd1, {31'd0, e_seen});
			compare("decode fail ack", 32'd0, {31'd0, a_seen});
			compare("decode fail s0 strobes", 32'(n0), 32'(s0_mem.adr_log.size()));
			compare("decode fail s1 strobes", 32'(n1), 32'(s1_mem.adr_log.size()));
			// Valid access right after the error
			ok_adr = (m == 0) ? 32'h0800 : 32'h1800;
			d = next_random();
			write_word("after decode fail", m, ok_adr, d);
			read_word("after decode fail", m, ok_adr, d);
		end
		report_test("decode_fail_access", e0);
	endtask

	task automatic shared_target_rr();
		int cnt [2];
		int owner, prev, e0;
		e0 = errors;
		cnt[0] = 0;
		cnt[1] = 0;
		prev = 0;
		// Master 0 owns S0 last so master 1 must win the first tie
		write_word("shared s0 warmup", 0, 32'h0000_0000, next_random());
		s0_mem.adr_log.delete();
		fork
			hammer("shared s0 m0", 0, 32'h0000_0000);
			hammer("shared s0 m1", 1, 32'h0000_0200);
		join
		compare("shared s0 log size", 32'(4 * N_WORDS), 32'(s0_mem.adr_log.size()));
		compare("round robin first owner", 32'd1, {31'd0, s0_mem.adr_log[0][9]});
		// Address bit 9 tells the masters apart
		for (int i = 0; i < s0_mem.adr_log.size(); i++) begin
			owner = int'(s0_mem.adr_log[i][9]);
			if (i > 0 && cnt[1 - prev] < 2 * N_WORDS) begin
				compare("round robin owner", 32'(1 - prev), 32'(owner));
			end
			cnt[owner]++;
			prev = owner;
		end
		report_test("shared_target_rr", e0);
	endtask

	task automatic split_targets();
		int foreign, e0;
		e0 = errors;
		foreign = 0;
		s0_mem.adr_log.delete();
		s1_mem.adr_log.delete();
		fork
			hammer("split m0 s0", 0, 32'h0000_0300);
			hammer("split m1 s1", 1, 32'h0000_1300);
		join
		compare("split s0 log size", 32'(2 * N_WORDS), 32'(s0_mem.adr_log.size()));
		compare("split s1 log size", 32'(2 * N_WORDS), 32'(s1_mem.adr_log.size()));
		// Each slave only sees its own master's window
		foreach (s0_mem.adr_log[i]) begin
			if (s0_mem.adr_log[i] < 32'h0300 || s0_mem.adr_log[i] >= 32'h0300 + 32'(4 * N_WORDS))
				foreign++;
		end
		foreach (s1_mem.adr_log[i]) begin
			if (s1_mem.adr_log[i] < 32'h1300 || s1_mem.adr_log[i] >= 32'h1300 + 32'(4 * N_WORDS))
				foreign++;
		end
		compare("split foreign addresses", 32'd0, 32'(foreign));
		report_test("split_targets", e0);
	endtask

	initial begin
		rstn = 1'b0;
		cyc = '0;
		stb = '0;
		we = '0;
		for (int m = 0; m < 2; m++) begin
			adr[m] = '0;
			sel[m] = '0;
			wdat[m] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		rstn = 1'b1;
		reset_values();
		single_master_rw("m0_s0_rw", 0, 32'h0000_0100);
		single_master_rw("m1_s1_rw", 1, 32'h0000_1100);
		decode_fail_access();
		shared_target_rr();
		split_targets();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== wb_xbar.f ====
verilog/wb_xbar_pkg.sv
verilog/wb_xbar_ctrl.sv
verilog/wb_rr_arbiter.sv
verilog/wb_req_mux.sv
verilog/wb_resp_mux.sv
verilog/wb_decode_err.sv
verilog/wb_xbar_top.sv
sim/wb_xbar_props.sv
sim/wb_xbar_tb.sv

// ==== Makefile ====
TOP := wb_xbar_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f wb_xbar.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
